//--- src.f
rtl/cache_pkg.sv
rtl/mem_pkg.sv
rtl/cache_way.sv
rtl/cache_ctrl.sv
rtl/main_mem.sv
rtl/cache_top.sv
sim/cache_sva.sv
sim/cache_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= src.f
VFLAGS    ?= --assert --timing
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Test OK"

clean:
	rm -rf $(OBJ_DIR)

//--- sim/cache_tb.sv
`timescale 1ns/100ps

module cache_tb;

    typedef struct packed {
        logic                         is_wr;
        logic                         hit;
        logic [cache_pkg::WORD_W-1:0] rdata;
        int                           latency;
    } expect_t;

    // Room for about 450 requests of up to 13 cycles each and a third more.
    localparam int TIMEOUT_CYCLES = 8000;

    logic              clk;
    logic              arst_n;
    mem_pkg::cpu_req_t req;
    mem_pkg::cpu_rsp_t rsp;

    int          cycle_cnt = 0;
    logic [31:0] rng;

    // Reference model state.
    logic [cache_pkg::SETS-1:0]   m_valid [2];
    logic [cache_pkg::SETS-1:0]   m_dirty [2];
    logic [cache_pkg::TAG_W-1:0]  m_tag   [2][cache_pkg::SETS];
    logic [cache_pkg::WORD_W-1:0] m_data  [2][cache_pkg::SETS][4];
    logic [cache_pkg::WORD_W-1:0] m_mem   [32768];
    logic                         m_victim;

    expect_t exp_q[$];
    string   name_q[$];
    int      start_q[$];

    cache_top u_cache_top (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .rsp    (rsp)
    );

    bind cache_top cache_sva u_sva (
        .clk     (clk),
        .arst_n  (arst_n),
        .req     (req),
        .rsp     (rsp),
        .mem_req (mem_req)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $fatal(1, "timeout");
        end
    end

    // ==================================================
    // Reference model
    // ==================================================

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic expect_t cache_model(input logic is_wr,
                                            input cache_pkg::cache_addr_u a,
                                            input logic [cache_pkg::WORD_W-1:0] wdata);
        expect_t                       e;
        logic [cache_pkg::TAG_W-1:0]   t;
        logic [cache_pkg::INDEX_W-1:0] ix;
        logic [1:0]                    w;
        logic [1:0]                    k;
        logic                          way;
        logic                          found;
        t       = a.f.tag;
        ix      = a.f.index;
        w       = a.f.offset[2:1];
        e       = '0;
        e.is_wr = is_wr;
        found   = 1'b1;
        way     = 1'b0;
        if (m_valid[0][ix] && m_tag[0][ix] == t) begin
            way = 1'b0;
        end else if (m_valid[1][ix] && m_tag[1][ix] == t) begin
            way = 1'b1;
        end else begin
            found = 1'b0;
        end
        if (found) begin
            e.hit     = 1'b1;
            e.latency = 1;
            if (is_wr) begin
                m_data[way][ix][w] = wdata;
                m_dirty[way][ix]   = 1'b1;
            end
        end else begin
            if (!m_valid[0][ix]) begin
                way = 1'b0;
            end else if (!m_valid[1][ix]) begin
                way = 1'b1;
            end else begin
                way = m_victim;
            end
            e.latency = 7;
            if (m_valid[way][ix] && m_dirty[way][ix]) begin
                e.latency = 11;
                for (int j = 0; j < 4; j++) begin
                    k = j[1:0];
                    m_mem[{m_tag[way][ix], ix, k}] = m_data[way][ix][k];
                end
            end
            for (int j = 0; j < 4; j++) begin
                k = j[1:0];
                m_data[way][ix][k] = m_mem[{t, ix, k}];
            end
            if (is_wr) begin
                m_data[way][ix][w] = wdata;
            end
            m_tag[way][ix]   = t;
            m_valid[way][ix] = 1'b1;
            m_dirty[way][ix] = is_wr;
            m_victim         = ~m_victim;
        end
        e.rdata = m_data[way][ix][w];
        return e;
    endfunction

    // ==================================================
    // Checks and stimulus
    // ==================================================

    task automatic check_word(input string name, input logic [cache_pkg::WORD_W-1:0] exp,
                              input logic [cache_pkg::WORD_W-1:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            $display("Test FAILED");
            $fatal(1, "read data mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
            $display("Test FAILED");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("CHECK FAILED %s latency: expected %0d, actual %0d", name, exp, act);
            $display("Test FAILED");
            $fatal(1, "latency mismatch");
        end
    endtask

    // Raise one request on a falling edge and hold it through the done cycle.
    task automatic do_request(input string name, input logic is_wr,
                              input logic [cache_pkg::ADDR_W-1:0] addr,
                              input logic [cache_pkg::WORD_W-1:0] wdata);
        cache_pkg::cache_addr_u a;
        a.raw = addr;
        @(negedge clk);
        exp_q.push_back(cache_model(is_wr, a, wdata));
        name_q.push_back(name);
        start_q.push_back(cycle_cnt);
        req.rd    = ~is_wr;
        req.wr    = is_wr;
        req.addr  = a;
        req.wdata = wdata;
        do begin
            @(negedge clk);
        end while (!rsp.done);
        @(negedge clk);
        req = '0;
    endtask

    always @(negedge clk) begin
        expect_t e;
        string   nm;
        int      lat;
        if (rsp.done) begin
            if (exp_q.size() == 0) begin
                $display("ERROR: done was raised with no request pending");
                $display("Test FAILED");
                $fatal(1, "unexpected done");
            end else begin
                e   = exp_q.pop_front();
                nm  = name_q.pop_front();
                lat = cycle_cnt - start_q.pop_front();
                check_flag({nm, " hit"}, e.hit, rsp.hit);
                check_latency(nm, e.latency, lat);
                if (!e.is_wr) begin
                    check_word({nm, " rdata"}, e.rdata, rsp.rdata);
                end
            end
        end
    end

    // ==================================================
    // Test sequence
    // ==================================================

    initial begin
        req        = '0;
        arst_n     = 1'b0;
        rng        = 32'h5343;
        m_valid[0] = '0;
        m_valid[1] = '0;
        m_dirty[0] = '0;
        m_dirty[1] = '0;
        m_victim   = 1'b0;
        for (logic [15:0] i = 16'd0; i < 16'h8000; i++) begin
            m_mem[i[14:0]] = i ^ 16'h5A5A;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        repeat (4) begin
            @(negedge clk);
            check_flag("reset stall", 1'b0, rsp.stall);
            check_flag("reset done", 1'b0, rsp.done);
            check_flag("reset hit", 1'b0, rsp.hit);
        end

        // Clean read miss followed by hits on the rest of the line.
        do_request("read miss", 1'b0, {5'd3, 8'h12, 3'd4}, 16'h0000);
        do_request("read hit w0", 1'b0, {5'd3, 8'h12, 3'd0}, 16'h0000);
        do_request("read hit w1", 1'b0, {5'd3, 8'h12, 3'd2}, 16'h0000);
        do_request("read hit w3", 1'b0, {5'd3, 8'h12, 3'd6}, 16'h0000);

        do_request("write hit", 1'b1, {5'd3, 8'h12, 3'd2}, 16'hBEEF);
        do_request("read after write hit", 1'b0, {5'd3, 8'h12, 3'd2}, 16'h0000);
        do_request("write miss", 1'b1, {5'd9, 8'h21, 3'd6}, 16'h1234);
        do_request("read after write miss", 1'b0, {5'd9, 8'h21, 3'd6}, 16'h0000);
        do_request("write miss line w0", 1'b0, {5'd9, 8'h21, 3'd0}, 16'h0000);
        do_request("write miss line w1", 1'b0, {5'd9, 8'h21, 3'd2}, 16'h0000);
        do_request("write miss line w2", 1'b0, {5'd9, 8'h21, 3'd4}, 16'h0000);

        // Three tags on one set force a dirty eviction.
        do_request("evict fill way0", 1'b1, {5'd1, 8'hC3, 3'd0}, 16'hA001);
        do_request("evict fill way1", 1'b1, {5'd2, 8'hC3, 3'd0}, 16'hA002);
        do_request("evict dirty", 1'b1, {5'd4, 8'hC3, 3'd0}, 16'hA004);
        do_request("evicted read back", 1'b0, {5'd1, 8'hC3, 3'd0}, 16'h0000);

        for (int n = 0; n < 400; n++) begin
            rng = xorshift(rng);
            do_request($sformatf("random %0d", n), rng[0],
                       {3'b001, rng[2:1], 6'b011000, rng[4:3], rng[7:5]}, rng[31:16]);
        end

        repeat (2) @(negedge clk);
        $display("Test OK");
        $finish;
    end

endmodule

//--- sim/cache_sva.sv
`timescale 1ns/100ps

module cache_sva (
    input logic              clk,
    input logic              arst_n,
    input mem_pkg::cpu_req_t req,
    input mem_pkg::cpu_rsp_t rsp,
    input mem_pkg::mem_req_t mem_req
);

    logic busy;

    // Request in progress, from the accepting edge to the edge that ends done.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
        end else if (rsp.done) begin
            busy <= 1'b0;
        end else if (!busy && (req.rd || req.wr)) begin
            busy <= 1'b1;
        end
    end

    done_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        rsp.done |=> !rsp.done)
        else $error("done stayed high for more than one cycle");

    done_in_request: assert property (@(posedge clk) disable iff (!arst_n)
        rsp.done |-> busy)
        else $error("done raised outside a request");

    mem_one_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        !(mem_req.rd && mem_req.wr))
        else $error("memory read and write strobes high together");

    stall_match: assert property (@(posedge clk) disable iff (!arst_n)
        rsp.stall == (rsp.done || busy))
        else $error("stall does not follow the request state");

    idle_no_mem: assert property (@(posedge clk) disable iff (!arst_n)
        !rsp.stall |-> (!mem_req.rd && !mem_req.wr))
        else $error("memory strobe while idle");

endmodule

//--- rtl/cache_top.sv
`timescale 1ns/100ps

module cache_top (
    input  logic              clk,
    input  logic              arst_n,
    input  mem_pkg::cpu_req_t req,
    output mem_pkg::cpu_rsp_t rsp
);

    cache_pkg::way_cmd_t way0_cmd;
    cache_pkg::way_cmd_t way1_cmd;
    cache_pkg::way_rsp_t way0_rsp;
    cache_pkg::way_rsp_t way1_rsp;
    mem_pkg::mem_req_t   mem_req;
    mem_pkg::mem_rsp_t   mem_rsp;

    cache_ctrl u_ctrl (
        .clk      (clk),
        .arst_n   (arst_n),
        .req      (req),
        .rsp      (rsp),
        .way0_cmd (way0_cmd),
        .way1_cmd (way1_cmd),
        .way0_rsp (way0_rsp),
        .way1_rsp (way1_rsp),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp)
    );

    cache_way u_way0 (
        .clk    (clk),
        .arst_n (arst_n),
        .cmd    (way0_cmd),
        .rsp    (way0_rsp)
    );

    cache_way u_way1 (
        .clk    (clk),
        .arst_n (arst_n),
        .cmd    (way1_cmd),
        .rsp    (way1_rsp)
    );

    main_mem u_mem (
        .clk     (clk),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

endmodule

//--- rtl/main_mem.sv
`timescale 1ns/100ps

module main_mem (
    input  logic              clk,
    input  mem_pkg::mem_req_t mem_req,
    output mem_pkg::mem_rsp_t mem_rsp
);

    localparam int DEPTH = 2 ** (cache_pkg::ADDR_W - 1);

    logic [cache_pkg::WORD_W-1:0] mem [DEPTH];
    logic [cache_pkg::WORD_W-1:0] stage1_q;
    logic [cache_pkg::WORD_W-1:0] stage2_q;
    logic [cache_pkg::ADDR_W-2:0] word_addr;

    // Byte address to word index.
    assign word_addr = mem_req.addr[cache_pkg::ADDR_W-1:1];

    // Known pattern so every word can be predicted.
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = i[cache_pkg::WORD_W-1:0] ^ 16'h5A5A;
        end
    end

    always @(posedge clk) begin
        if (mem_req.wr) begin
            mem[word_addr] <= mem_req.wdata;
        end
    end

    // Two stage read pipeline.
    always_ff @(posedge clk) begin
        if (mem_req.rd) begin
            stage1_q <= mem[word_addr];
        end
        stage2_q <= stage1_q;
    end

    assign mem_rsp.rdata = stage2_q;

endmodule

//--- rtl/cache_ctrl.sv
`timescale 1ns/100ps

module cache_ctrl (
    input  logic                clk,
    input  logic                arst_n,
    input  mem_pkg::cpu_req_t   req,
    output mem_pkg::cpu_rsp_t   rsp,
    output cache_pkg::way_cmd_t way0_cmd,
    output cache_pkg::way_cmd_t way1_cmd,
    input  cache_pkg::way_rsp_t way0_rsp,
    input  cache_pkg::way_rsp_t way1_rsp,
    output mem_pkg::mem_req_t   mem_req,
    input  mem_pkg::mem_rsp_t   mem_rsp
);

    typedef enum logic [1:0] {
        IDLE,
        COMPARE,
        WBACK,
        FILL
    } state_t;

    state_t state;
    state_t state_nxt;
    logic [2:0] cnt;
    logic [2:0] cnt_nxt;
    logic [2:0] fill_beat;
    logic       sel_q;
    logic       victim_q;
    logic       way_pick;
    logic       any_hit;
    logic       dirty_evict;
    logic       word_match;
    logic       bcast;

    logic [cache_pkg::WORD_W-1:0] rdata_q;
    logic [cache_pkg::WORD_W-1:0] hit_rdata;

    cache_pkg::way_cmd_t    cmd;
    cache_pkg::way_rsp_t    sel_rsp;
    cache_pkg::cache_addr_u wb_addr;
    cache_pkg::cache_addr_u rd_addr;

    // ==================================================
    // Way selection
    // ==================================================

    assign any_hit   = way0_rsp.hit | way1_rsp.hit;
    assign hit_rdata = way1_rsp.hit ? way1_rsp.rdata : way0_rsp.rdata;
    assign sel_rsp   = sel_q ? way1_rsp : way0_rsp;

    // Hit first, then an empty way, then the victim.
    always_comb begin
        if (way0_rsp.hit) begin
            way_pick = 1'b0;
        end else if (way1_rsp.hit) begin
            way_pick = 1'b1;
        end else if (!way0_rsp.valid) begin
            way_pick = 1'b0;
        end else if (!way1_rsp.valid) begin
            way_pick = 1'b1;
        end else begin
            way_pick = victim_q;
        end
    end

    assign dirty_evict = ~any_hit & (way_pick ? (way1_rsp.valid & way1_rsp.dirty)
                                              : (way0_rsp.valid & way0_rsp.dirty));

    // ==================================================
    // Sequencing
    // ==================================================

    // Read data comes back two beats after its strobe.
    assign fill_beat  = cnt - 3'd2;
    assign word_match = (fill_beat[1:0] == req.addr.f.offset[2:1]);

    always_comb begin
        wb_addr          = req.addr;
        wb_addr.f.tag    = sel_rsp.tag_out;
        wb_addr.f.offset = {cnt[1:0], 1'b0};
        rd_addr          = req.addr;
        rd_addr.f.offset = {cnt[1:0], 1'b0};
    end

    always_comb begin
        state_nxt = state;
        cnt_nxt   = cnt;
        bcast     = 1'b0;
        cmd       = '0;
        mem_req   = '0;
        rsp       = '0;
        rsp.stall = (state != IDLE);

        case (state)
            IDLE: begin
                if (req.rd || req.wr) begin
                    state_nxt = COMPARE;
                end
            end
            COMPARE: begin
                bcast      = 1'b1;
                cmd.enable = 1'b1;
                cmd.comp   = 1'b1;
                cmd.write  = req.wr;
                cmd.tag    = req.addr.f.tag;
                cmd.index  = req.addr.f.index;
                cmd.offset = req.addr.f.offset;
                cmd.wdata  = req.wdata;
                rsp.done   = any_hit;
                rsp.hit    = any_hit;
                rsp.rdata  = hit_rdata;
                cnt_nxt    = 3'd0;
                if (any_hit) begin
                    state_nxt = IDLE;
                end else if (dirty_evict) begin
                    state_nxt = WBACK;
                end else begin
                    state_nxt = FILL;
                end
            end
            WBACK: begin
                cmd.enable    = 1'b1;
                cmd.index     = req.addr.f.index;
                cmd.offset    = {cnt[1:0], 1'b0};
                mem_req.wr    = 1'b1;
                mem_req.addr  = wb_addr.raw;
                mem_req.wdata = sel_rsp.rdata;
                if (cnt == 3'd3) begin
                    cnt_nxt   = 3'd0;
                    state_nxt = FILL;
                end else begin
                    cnt_nxt = cnt + 3'd1;
                end
            end
            FILL: begin
                cmd.enable = 1'b1;
                cmd.tag    = req.addr.f.tag;
                cmd.index  = req.addr.f.index;
                if (cnt < 3'd4) begin
                    mem_req.rd   = 1'b1;
                    mem_req.addr = rd_addr.raw;
                end
                if (cnt >= 3'd2) begin
                    cmd.write    = 1'b1;
                    cmd.valid_in = 1'b1;
                    cmd.offset   = {fill_beat[1:0], 1'b0};
                    cmd.wdata    = (req.wr && word_match) ? req.wdata : mem_rsp.rdata;
                end
                if (cnt == 3'd5) begin
                    // Compare on the last beat marks a write miss line dirty.
                    cmd.comp  = req.wr;
                    rsp.done  = 1'b1;
                    rsp.rdata = word_match ? mem_rsp.rdata : rdata_q;
                    state_nxt = IDLE;
                end else begin
                    cnt_nxt = cnt + 3'd1;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_comb begin
        way0_cmd        = cmd;
        way1_cmd        = cmd;
        way0_cmd.enable = cmd.enable & (bcast | ~sel_q);
        way1_cmd.enable = cmd.enable & (bcast | sel_q);
    end

    // ==================================================
    // State
    // ==================================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            cnt      <= 3'd0;
            sel_q    <= 1'b0;
            victim_q <= 1'b0;
        end else begin
            state <= state_nxt;
            cnt   <= cnt_nxt;
            if (state == COMPARE) begin
                sel_q <= way_pick;
            end
            if (state == FILL && cnt == 3'd5) begin
                victim_q <= ~victim_q;
            end
        end
    end

    // Requested word of a read miss, kept until done.
    always_ff @(posedge clk) begin
        if (state == FILL && cnt >= 3'd2 && word_match) begin
            rdata_q <= mem_rsp.rdata;
        end
    end

endmodule

//--- rtl/cache_way.sv
`timescale 1ns/100ps

module cache_way (
    input  logic                clk,
    input  logic                arst_n,
    input  cache_pkg::way_cmd_t cmd,
    output cache_pkg::way_rsp_t rsp
);

    logic [cache_pkg::TAG_W-1:0]  tag_mem  [cache_pkg::SETS];
    logic [cache_pkg::WORD_W-1:0] data_mem [cache_pkg::SETS][4];
    logic [cache_pkg::SETS-1:0]   valid_q;
    logic [cache_pkg::SETS-1:0]   dirty_q;

    logic [1:0] word;
    logic       tag_eq;
    logic       fill_we;
    logic       upd_we;

    // Byte offset bit 0 selects a byte inside the word and is ignored.
    assign word   = cmd.offset[2:1];
    assign tag_eq = (tag_mem[cmd.index] == cmd.tag);

    always_comb begin
        rsp.valid   = valid_q[cmd.index];
        rsp.dirty   = dirty_q[cmd.index];
        rsp.tag_out = tag_mem[cmd.index];
        rsp.rdata   = data_mem[cmd.index][word];
        rsp.hit     = cmd.enable & cmd.comp & valid_q[cmd.index] & tag_eq;
    end

    // Fill beat without compare, or a compare write that hit.
    assign fill_we = cmd.enable & cmd.write & ~cmd.comp;
    assign upd_we  = cmd.write & rsp.hit;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_we) begin
            valid_q[cmd.index] <= cmd.valid_in;
            dirty_q[cmd.index] <= 1'b0;
        end else if (upd_we) begin
            dirty_q[cmd.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we) begin
            tag_mem[cmd.index] <= cmd.tag;
        end
        if (fill_we || upd_we) begin
            data_mem[cmd.index][word] <= cmd.wdata;
        end
    end

endmodule

//--- rtl/mem_pkg.sv
package mem_pkg;

    // Processor side.
    typedef struct packed {
        logic                          rd;
        logic                          wr;
        cache_pkg::cache_addr_u        addr;
        logic [cache_pkg::WORD_W-1:0]  wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                          done;
        logic                          stall;
        logic                          hit;
        logic [cache_pkg::WORD_W-1:0]  rdata;
    } cpu_rsp_t;

    // Memory side, byte addressed.
    typedef struct packed {
        logic                          rd;
        logic                          wr;
        logic [cache_pkg::ADDR_W-1:0]  addr;
        logic [cache_pkg::WORD_W-1:0]  wdata;
    } mem_req_t;

    typedef struct packed {
        logic [cache_pkg::WORD_W-1:0]  rdata;
    } mem_rsp_t;

endpackage

//--- rtl/cache_pkg.sv
package cache_pkg;

    // ==================================================
    // Geometry
    // ==================================================

    localparam int TAG_W    = 5;
    localparam int INDEX_W  = 8;
    localparam int OFFSET_W = 3;
    localparam int WORD_W   = 16;
    localparam int ADDR_W   = TAG_W + INDEX_W + OFFSET_W;
    localparam int SETS     = 256;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } cache_addr_t;

    // Same byte address, either as a plain word or split into fields.
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        cache_addr_t       f;
    } cache_addr_u;

    typedef struct packed {
        logic                enable;
        logic                comp;
        logic                write;
        logic                valid_in;
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
        logic [WORD_W-1:0]   wdata;
    } way_cmd_t;

    typedef struct packed {
        logic              hit;
        logic              valid;
        logic              dirty;
        logic [TAG_W-1:0]  tag_out;
        logic [WORD_W-1:0] rdata;
    } way_rsp_t;

endpackage
